//--- dram_pkg.sv
package dram_pkg;

  localparam int UI_ADDR_W = 27; // address width of the controller user interface.

  localparam logic [2:0] CMD_WRITE = 3'b000;
  localparam logic [2:0] CMD_READ  = 3'b001;

  // request from the CPU memory port.
  typedef struct packed {
    logic        mem_valid;
    logic        mem_instr;
    logic [1:0]  mem_mode;
    logic [31:0] mem_addr;
    logic [63:0] mem_wdata;
    logic [7:0]  mem_wstrb;
  } mem_req_t;

  typedef struct packed {
    logic [63:0] mem_rdata;
    logic        mem_ready;
    logic        mem_error;
  } mem_resp_t;

  // bridge outputs toward the DDR2 controller.
  typedef struct packed {
    logic [UI_ADDR_W-1:0] app_addr;
    logic [2:0]           app_cmd;
    logic                 app_en;
    logic [127:0]         app_wdf_data;
    logic                 app_wdf_end;
    logic [15:0]          app_wdf_mask; // a set bit leaves the byte unwritten.
    logic                 app_wdf_wren;
  } ui_cmd_t;

  typedef struct packed {
    logic         app_rdy;
    logic         app_wdf_rdy;
    logic [127:0] app_rd_data;
    logic         app_rd_data_valid;
    logic         app_rd_data_end;
  } ui_rsp_t;

  // formatted request handed from the packer to the sequencer.
  typedef struct packed {
    logic [UI_ADDR_W-1:0] line_addr;
    logic [127:0]         data;
    logic [15:0]          mask;
    logic                 is_write;
    logic                 lane; // selects the upper 64-bit half when set.
  } wr_line_t;

  typedef enum logic [2:0] {
    st_idle,
    st_preset,
    st_send_data,
    st_set_cmd_wr,
    st_set_cmd_rd,
    st_recv_data
  } seq_state_t;

endpackage

//--- wdf_packer.sv
`timescale 1ns/1ns

module wdf_packer
  import dram_pkg::*;
#(
  parameter int APP_ADDR_W = 27
) (
  input  logic     app_ui_clk,
  input  logic     app_ui_rst,
  input  mem_req_t mem_in,
  input  logic     accept,
  output wr_line_t line
);

  logic [APP_ADDR_W-1:0] addr_nxt;
  logic [15:0]           mask_nxt;
  logic                  lane_nxt;

  assign lane_nxt = mem_in.mem_addr[3];

  // lines are 16 bytes wide, so the low nibble of the line address is zero.
  assign addr_nxt = {mem_in.mem_addr[APP_ADDR_W-1:4], 4'b0000};

  always_comb begin
    mask_nxt = 16'hffff;
    if (lane_nxt) begin
      mask_nxt[15:8] = ~mem_in.mem_wstrb;
    end else begin
      mask_nxt[7:0] = ~mem_in.mem_wstrb;
    end
  end

  always_ff @(posedge app_ui_clk) begin
    if (accept) begin
      line.line_addr <= UI_ADDR_W'(addr_nxt);
      line.data      <= {mem_in.mem_wdata, mem_in.mem_wdata}; // same word in both halves.
      line.mask      <= mask_nxt;
    end
    if (app_ui_rst) begin
      line.is_write <= 1'b0;
      line.lane     <= 1'b0;
    end else if (accept) begin
      line.is_write <= |mem_in.mem_wstrb; // an empty strobe marks a read.
      line.lane     <= lane_nxt;
    end
  end

endmodule

//--- cmd_sequencer.sv
`timescale 1ns/1ns

module cmd_sequencer
  import dram_pkg::*;
#(
  parameter int APP_ADDR_W = 27
) (
  input  logic     app_ui_clk,
  input  logic     app_ui_rst,
  input  logic     mem_valid,
  input  logic     calib_complete,
  input  wr_line_t line,
  input  ui_rsp_t  ui_in,
  output ui_cmd_t  ui_out,
  output logic     accept,
  output logic     done
);

  // clears address bits beyond the range of the attached device.
  localparam logic [UI_ADDR_W-1:0] ADDR_MASK = UI_ADDR_W'((64'd1 << APP_ADDR_W) - 64'd1);

  seq_state_t state;
  seq_state_t state_nxt;
  logic       resp_hold;
  logic       done_nxt;

  // the CPU still holds mem_valid while the response is on its way,
  // so a new request waits until done and the following cycle are past.
  assign accept = (state == st_idle) && mem_valid && calib_complete &&
                  !done && !resp_hold;

  always_comb begin
    state_nxt = state;
    unique case (state)
      st_idle: begin
        if (accept) begin
          state_nxt = st_preset;
        end
      end
      st_preset: begin
        if (line.is_write) begin
          state_nxt = st_send_data;
        end else begin
          state_nxt = st_set_cmd_rd;
        end
      end
      st_send_data: begin
        if (ui_in.app_wdf_rdy) begin
          state_nxt = st_set_cmd_wr;
        end
      end
      st_set_cmd_wr: begin
        if (ui_in.app_rdy) begin
          state_nxt = st_idle;
        end
      end
      st_set_cmd_rd: begin
        if (ui_in.app_rdy) begin
          state_nxt = st_recv_data;
        end
      end
      st_recv_data: begin
        if (ui_in.app_rd_data_valid) begin
          state_nxt = st_idle;
        end
      end
      default: begin
        state_nxt = st_idle;
      end
    endcase
  end

  assign done_nxt = ((state == st_set_cmd_wr) && ui_in.app_rdy) ||
                    ((state == st_recv_data) && ui_in.app_rd_data_valid);

  always_ff @(posedge app_ui_clk) begin
    if (state == st_preset) begin
      ui_out.app_addr     <= line.line_addr & ADDR_MASK;
      ui_out.app_wdf_data <= line.data;
      ui_out.app_wdf_mask <= line.mask;
    end
    if (app_ui_rst) begin
      state               <= st_idle;
      ui_out.app_en       <= 1'b0;
      ui_out.app_cmd      <= CMD_WRITE;
      ui_out.app_wdf_wren <= 1'b0;
      ui_out.app_wdf_end  <= 1'b0;
      done                <= 1'b0;
      resp_hold           <= 1'b0;
    end else begin
      state               <= state_nxt;
      ui_out.app_wdf_wren <= (state_nxt == st_send_data);
      ui_out.app_wdf_end  <= (state_nxt == st_send_data); // one beat per line.
      ui_out.app_en       <= (state_nxt == st_set_cmd_wr) || (state_nxt == st_set_cmd_rd);
      ui_out.app_cmd      <= (state_nxt == st_set_cmd_rd) ? CMD_READ : CMD_WRITE;
      done                <= done_nxt;
      resp_hold           <= done;
    end
  end

endmodule

//--- rd_lane_select.sv
`timescale 1ns/1ns

module rd_lane_select
  import dram_pkg::*;
(
  input  logic         app_ui_clk,
  input  logic         app_ui_rst,
  input  logic         done,
  input  logic         lane,
  input  logic         rd_valid,
  input  logic [127:0] rd_line,
  output mem_resp_t    mem_out
);

  logic [127:0] rd_line_q;
  logic [63:0]  rd_word;

  always_ff @(posedge app_ui_clk) begin
    if (rd_valid) begin
      rd_line_q <= rd_line; // kept until the next read returns.
    end
  end

  always_comb begin
    if (lane) begin
      rd_word = rd_line_q[127:64];
    end else begin
      rd_word = rd_line_q[63:0];
    end
  end

  // a write completion also returns the stale line half, so clear it unless done.
  always_ff @(posedge app_ui_clk) begin
    if (app_ui_rst) begin
      mem_out <= '0;
    end else begin
      mem_out.mem_ready <= done;
      mem_out.mem_rdata <= done ? rd_word : 64'd0;
      mem_out.mem_error <= 1'b0; // the controller reports no errors.
    end
  end

endmodule

//--- dram_bridge.sv
`timescale 1ns/1ns

module dram_bridge
  import dram_pkg::*;
#(
  parameter int APP_ADDR_W = 27
) (
  input  logic      app_ui_clk,
  input  logic      app_ui_rst,
  input  logic      calib_complete,
  input  mem_req_t  mem_in,
  input  ui_rsp_t   ui_in,
  output mem_resp_t mem_out,
  output ui_cmd_t   ui_out
);

  wr_line_t line;
  logic     accept;
  logic     done;

  wdf_packer #(
    .APP_ADDR_W (APP_ADDR_W)
  ) u_wdf_packer (
    .app_ui_clk (app_ui_clk),
    .app_ui_rst (app_ui_rst),
    .mem_in     (mem_in),
    .accept     (accept),
    .line       (line)
  );

  cmd_sequencer #(
    .APP_ADDR_W (APP_ADDR_W)
  ) u_cmd_sequencer (
    .app_ui_clk     (app_ui_clk),
    .app_ui_rst     (app_ui_rst),
    .mem_valid      (mem_in.mem_valid),
    .calib_complete (calib_complete),
    .line           (line),
    .ui_in          (ui_in),
    .ui_out         (ui_out),
    .accept         (accept),
    .done           (done)
  );

  rd_lane_select u_rd_lane_select (
    .app_ui_clk (app_ui_clk),
    .app_ui_rst (app_ui_rst),
    .done       (done),
    .lane       (line.lane),
    .rd_valid   (ui_in.app_rd_data_valid),
    .rd_line    (ui_in.app_rd_data),
    .mem_out    (mem_out)
  );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD_NS  = 20,
  parameter int RST_CYCLES = 10
) (
  output logic app_ui_clk,
  output logic app_ui_rst
);

  initial begin
    app_ui_clk = 1'b0;
    forever #(PERIOD_NS / 2) app_ui_clk = ~app_ui_clk;
  end

  initial begin
    app_ui_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge app_ui_clk);
    app_ui_rst <= 1'b0; // released on a rising edge like any other input.
  end

endmodule

//--- ui_mem_model.sv
`timescale 1ns/1ns

module ui_mem_model
  import dram_pkg::*;
#(
  parameter int          RD_DELAY = 3,
  parameter logic [15:0] SEED     = 16'd67
) (
  input  logic    app_ui_clk,
  input  logic    app_ui_rst,
  input  logic    stall_en,
  input  ui_cmd_t ui_out,
  output ui_rsp_t ui_in,
  output logic    calib_complete = 1'b0
);

  logic [127:0] mem [64];
  logic [127:0] wdf_data_q;
  logic [15:0]  wdf_mask_q;
  logic [127:0] rd_data_q = '0;
  logic         rd_valid_q = 1'b0;
  logic         rdy_q = 1'b0;
  logic         wdf_rdy_q = 1'b0;
  logic [3:0]   rd_cnt = '0;
  logic [2:0]   calib_cnt = '0;
  logic [15:0]  lfsr;
  logic [15:0]  lfsr_a;
  logic [15:0]  lfsr_b;
  logic [5:0]   cmd_idx;
  logic         cmd_fire;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  function automatic logic [127:0] fill_line(input int unsigned idx);
    logic [31:0] a;
    a = idx * 32'h0101_0101;
    fill_line = {a ^ 32'hdead_beef, a ^ 32'h1234_5678, ~a, a ^ 32'h0f1e_2d3c};
  endfunction

  assign lfsr_a   = lfsr_next(lfsr);
  assign lfsr_b   = lfsr_next(lfsr_a);
  assign cmd_idx  = ui_out.app_addr[9:4];
  assign cmd_fire = ui_out.app_en && rdy_q;

  assign ui_in = '{app_rdy: rdy_q, app_wdf_rdy: wdf_rdy_q, app_rd_data: rd_data_q,
                   app_rd_data_valid: rd_valid_q, app_rd_data_end: rd_valid_q};

  always @(posedge app_ui_clk) begin
    if (app_ui_rst) begin
      for (int i = 0; i < 64; i++) begin
        mem[i] <= fill_line(i);
      end
      lfsr       <= SEED;
      rdy_q      <= 1'b1;
      wdf_rdy_q  <= 1'b1;
      rd_cnt     <= '0;
      rd_valid_q <= 1'b0;
      calib_cnt  <= '0;
      calib_complete <= 1'b0;
    end else begin
      if (stall_en) begin
        rdy_q     <= ~lfsr[0]; // one LFSR bit per ready flag.
        wdf_rdy_q <= ~lfsr_a[0];
        lfsr      <= lfsr_b;
      end else begin
        rdy_q     <= 1'b1;
        wdf_rdy_q <= 1'b1;
      end
      if (ui_out.app_wdf_wren && wdf_rdy_q) begin
        wdf_data_q <= ui_out.app_wdf_data;
        wdf_mask_q <= ui_out.app_wdf_mask;
      end
      if (cmd_fire && ui_out.app_cmd == CMD_WRITE) begin
        for (int b = 0; b < 16; b++) begin
          if (!wdf_mask_q[b]) begin
            mem[cmd_idx][8*b +: 8] <= wdf_data_q[8*b +: 8];
          end
        end
      end
      rd_valid_q <= (rd_cnt == 4'd1);
      if (rd_cnt == 4'd1) begin
        rd_data_q <= mem[cmd_idx];
      end
      if (cmd_fire && ui_out.app_cmd == CMD_READ) begin
        rd_cnt <= 4'(RD_DELAY);
      end else if (rd_cnt != 4'd0) begin
        rd_cnt <= rd_cnt - 4'd1;
      end
      if (calib_cnt != 3'd5) begin
        calib_cnt <= calib_cnt + 3'd1;
      end
      calib_complete <= (calib_cnt == 3'd5);
    end
  end

endmodule

//--- tb_dram_bridge.sv
`timescale 1ns/1ns

module tb_dram_bridge
  import dram_pkg::*;
();

  localparam int          N_TRANS        = 31;
  localparam int          TIMEOUT_CYCLES = 40 * N_TRANS + 100;
  localparam int          RAND_TXNS      = 20;
  localparam logic [15:0] LFSR_SEED      = 16'd67;

  logic         app_ui_clk;
  logic         app_ui_rst;
  logic         calib_complete;
  logic         stall_en;
  mem_req_t     mem_in;
  mem_resp_t    mem_out;
  ui_rsp_t      ui_in;
  ui_cmd_t      ui_out;
  ui_cmd_t      prev_cmd = '0;
  ui_rsp_t      prev_rsp = '0;
  logic [127:0] ref_mem [64];
  logic [127:0] last_rd_line;
  logic [15:0]  lfsr_state;
  string        test_name = "startup";
  int           err_cnt = 0;
  int           pass_cnt = 0;
  int           fail_cnt = 0;
  int           stall_seen = 0;
  int           cycle_cnt = 0;

  tb_clock_gen u_clock_gen (.app_ui_clk(app_ui_clk), .app_ui_rst(app_ui_rst));

  dram_bridge #(.APP_ADDR_W(27)) UUT (
    .app_ui_clk     (app_ui_clk),
    .app_ui_rst     (app_ui_rst),
    .calib_complete (calib_complete),
    .mem_in         (mem_in),
    .ui_in          (ui_in),
    .mem_out        (mem_out),
    .ui_out         (ui_out)
  );

  ui_mem_model u_mem_model (
    .app_ui_clk     (app_ui_clk),
    .app_ui_rst     (app_ui_rst),
    .stall_en       (stall_en),
    .ui_out         (ui_out),
    .ui_in          (ui_in),
    .calib_complete (calib_complete)
  );

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  function automatic logic [127:0] fill_line(input int unsigned idx);
    logic [31:0] a;
    a = idx * 32'h0101_0101;
    fill_line = {a ^ 32'hdead_beef, a ^ 32'h1234_5678, ~a, a ^ 32'h0f1e_2d3c};
  endfunction

  function automatic logic [63:0] expected_word(input logic [31:0] addr);
    expected_word = addr[3] ? ref_mem[addr[9:4]][127:64] : ref_mem[addr[9:4]][63:0];
  endfunction

  task automatic rand_bits(input int n, output logic [63:0] v);
    v = '0;
    repeat (n) begin
      v = {v[62:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // only strobed bytes of the addressed half change.
  task automatic ref_write(input logic [31:0] addr, input logic [63:0] wdata,
                          input logic [7:0] wstrb);
    for (int b = 0; b < 8; b++) begin
      if (wstrb[b]) begin
        ref_mem[addr[9:4]][64*addr[3] + 8*b +: 8] = wdata[8*b +: 8];
      end
    end
  endtask

  task automatic check_resp(input string what, input mem_resp_t exp, input mem_resp_t act);
    if (act !== exp) begin
      $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_cmd(input string what, input ui_cmd_t exp, input ui_cmd_t act,
                           input ui_cmd_t care);
    if (((exp ^ act) & care) !== '0) begin
      $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp & care,
               act & care);
      err_cnt++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_cnt = 0;
  endtask

  task automatic end_test();
    if (err_cnt == 0) begin
      pass_cnt++;
      $display("test %s: ok", test_name);
    end else begin
      fail_cnt++;
      $display("test %s: failed with %0d errors", test_name, err_cnt);
    end
  endtask

  task automatic start_request(input logic [31:0] addr, input logic [63:0] wdata,
                               input logic [7:0] wstrb);
    mem_req_t req;
    req = '0;
    req.mem_valid = 1'b1;
    req.mem_addr  = addr;
    req.mem_wdata = wdata;
    req.mem_wstrb = wstrb;
    @(posedge app_ui_clk);
    mem_in <= req;
  endtask

  task automatic finish_request(input logic [31:0] addr, input logic [63:0] wdata,
                                input logic [7:0] wstrb);
    mem_resp_t resp;
    mem_resp_t exp;
    @(negedge app_ui_clk);
    while (!mem_out.mem_ready) @(negedge app_ui_clk);
    resp = mem_out;
    @(posedge app_ui_clk);
    mem_in <= '0;
    exp = '0;
    exp.mem_ready = 1'b1;
    if (wstrb != 8'h00) begin
      ref_write(addr, wdata, wstrb);
      // a write response carries the addressed half of the line from the last read.
      exp.mem_rdata = addr[3] ? last_rd_line[127:64] : last_rd_line[63:0];
      check_resp("write response", exp, resp);
    end else begin
      exp.mem_rdata = expected_word(addr);
      last_rd_line = ref_mem[addr[9:4]];
      check_resp("read response", exp, resp);
    end
    @(negedge app_ui_clk);
    if (mem_out.mem_ready) begin
      $display("test %s: mem_ready stayed high for more than one cycle", test_name);
      err_cnt++;
    end
  endtask

  task automatic run_txn(input logic [31:0] addr, input logic [63:0] wdata,
                         input logic [7:0] wstrb);
    start_request(addr, wdata, wstrb);
    finish_request(addr, wdata, wstrb);
  endtask

  task automatic test_reset_and_calib();
    ui_cmd_t exp_cmd;
    ui_cmd_t care;
    begin_test("reset_and_calib");
    @(negedge app_ui_rst);
    @(negedge app_ui_clk);
    exp_cmd = '0;
    care = '0;
    care.app_en       = 1'b1;
    care.app_wdf_wren = 1'b1;
    care.app_wdf_end  = 1'b1;
    check_cmd("idle strobes", exp_cmd, ui_out, care);
    check_resp("idle response", '0, mem_out);
    if (calib_complete) begin
      $display("test %s: calib_complete was already high after reset", test_name);
      err_cnt++;
    end
    start_request(32'h0000_0040, 64'd0, 8'h00);
    while (!calib_complete) begin
      @(negedge app_ui_clk);
      check_cmd("app_en before calibration", exp_cmd, ui_out, care);
    end
    finish_request(32'h0000_0040, 64'd0, 8'h00);
    end_test();
  endtask

  task automatic test_write_read();
    ui_cmd_t     exp_cmd;
    ui_cmd_t     care;
    logic [31:0] addr;
    logic [63:0] word;
    begin_test("write_then_read");
    addr = 32'h0000_0120;
    word = 64'h0123_4567_89ab_cdef;
    start_request(addr, word, 8'hff);
    @(negedge app_ui_clk);
    while (!ui_out.app_wdf_wren) @(negedge app_ui_clk);
    exp_cmd = '0;
    exp_cmd.app_addr     = UI_ADDR_W'(addr) & ~UI_ADDR_W'(15);
    exp_cmd.app_wdf_data = {word, word};
    exp_cmd.app_wdf_mask = 16'hff00; // lower half written, upper half masked.
    exp_cmd.app_wdf_wren = 1'b1;
    exp_cmd.app_wdf_end  = 1'b1;
    care = '1;
    care.app_cmd = '0;
    check_cmd("write data beat", exp_cmd, ui_out, care);
    while (!ui_out.app_en) @(negedge app_ui_clk);
    exp_cmd.app_cmd      = CMD_WRITE;
    exp_cmd.app_en       = 1'b1;
    exp_cmd.app_wdf_wren = 1'b0;
    exp_cmd.app_wdf_end  = 1'b0;
    check_cmd("write command", exp_cmd, ui_out, '1);
    finish_request(addr, word, 8'hff);
    run_txn(addr, 64'd0, 8'h00);
    end_test();
  endtask

  task automatic test_lanes();
    begin_test("independent_lanes");
    run_txn(32'h0000_0340, 64'h1111_2222_3333_4444, 8'hff);
    run_txn(32'h0000_0348, 64'haaaa_bbbb_cccc_dddd, 8'hff);
    run_txn(32'h0000_0340, 64'd0, 8'h00);
    run_txn(32'h0000_0348, 64'd0, 8'h00);
    end_test();
  endtask

  task automatic test_partial_write();
    begin_test("partial_strobe");
    run_txn(32'h0000_05a8, 64'hfedc_ba98_7654_3210, 8'hff);
    run_txn(32'h0000_05a8, 64'h5a5a_5a5a_a5a5_a5a5, 8'ha5);
    run_txn(32'h0000_05a8, 64'd0, 8'h00);
    run_txn(32'h0000_05a0, 64'd0, 8'h00);
    end_test();
  endtask

  task automatic test_random_stalls();
    logic [63:0] r;
    logic [63:0] data;
    logic [31:0] addr;
    logic [7:0]  strb;
    begin_test("random_with_stalls");
    stall_seen = 0;
    @(posedge app_ui_clk);
    stall_en <= 1'b1;
    for (int n = 0; n < RAND_TXNS; n++) begin
      rand_bits(7, r);
      addr = {22'd0, r[6:1], r[0], 3'b000};
      rand_bits(64, data);
      rand_bits(8, r);
      strb = r[7:0];
      rand_bits(1, r);
      if (r[0]) begin
        strb = 8'h00;
      end
      run_txn(addr, data, strb);
    end
    @(posedge app_ui_clk);
    stall_en <= 1'b0;
    if (stall_seen == 0) begin
      $display("test %s: app_rdy never stalled a command", test_name);
      err_cnt++;
    end
    end_test();
  endtask

  // a stalled strobe must keep the whole command unchanged.
  always @(negedge app_ui_clk) begin
    if (!app_ui_rst) begin
      if ((prev_cmd.app_en && !prev_rsp.app_rdy) ||
          (prev_cmd.app_wdf_wren && !prev_rsp.app_wdf_rdy)) begin
        check_cmd("held command", prev_cmd, ui_out, '1);
        if (prev_cmd.app_en) begin
          stall_seen++;
        end
      end
    end
    prev_cmd = ui_out;
    prev_rsp = ui_in;
  end

  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge app_ui_clk);
      cycle_cnt++;
    end
    $display("timeout: run exceeded %0d cycles during test %s", TIMEOUT_CYCLES, test_name);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    mem_in = '0;
    stall_en = 1'b0;
    lfsr_state = LFSR_SEED;
    last_rd_line = '0;
    for (int i = 0; i < 64; i++) begin
      ref_mem[i] = fill_line(i);
    end
    test_reset_and_calib();
    test_write_read();
    test_lanes();
    test_partial_write();
    test_random_stalls();
    $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- compile.f
dram_pkg.sv
wdf_packer.sv
cmd_sequencer.sv
rd_lane_select.sv
dram_bridge.sv
tb_clock_gen.sv
ui_mem_model.sv
tb_dram_bridge.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dram_bridge
RTL_TOP   ?= dram_bridge
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
RTL_SRCS  ?= dram_pkg.sv wdf_packer.sv cmd_sequencer.sv rd_lane_select.sv dram_bridge.sv
PASS_MSG  ?= Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) -Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
